/* hw/regcore_pkg.sv */
`default_nettype none

package regcore_pkg;

	////////////////////
	// Widths

	localparam int DATA_W    = 32;
	localparam int REG_COUNT = 32;
	localparam int ADDR_W    = 5;
	localparam int IMM_W     = 16;

	// Index of the last register in a dump walk
	localparam logic [ADDR_W-1:0] LAST_REG = ADDR_W'(REG_COUNT - 1);

	typedef logic [DATA_W-1:0] word_t;

	////////////////////
	// Opcodes

	typedef enum logic [2:0]
	{
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5, // Signed compare, 1 or 0
		OP_LI   = 3'd6, // Zero-extended immediate
		OP_DUMP = 3'd7  // Stream out the whole bank
	} op_t;

	////////////////////
	// Records

	typedef struct packed
	{
		op_t               op;
		logic [ADDR_W-1:0] rs;
		logic [ADDR_W-1:0] rt;
		logic [ADDR_W-1:0] rd;
		logic [IMM_W-1:0]  imm; // Only for OP_LI
	} cmd_t;

	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              dump; // Record belongs to a dump
	} result_t;

endpackage

`default_nettype wire

/* hw/cmd_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_receiver
(
	input  logic              clk,
	input  logic              reset,
	input  logic              in_req,
	input  regcore_pkg::cmd_t in_cmd,
	output logic              in_ack,
	output logic              cmd_valid,
	output regcore_pkg::cmd_t cmd,
	input  logic              cmd_ready
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_ACK,          // Ack high, waiting for req to drop
		S_WAIT_RELEASE  // Req seen, slot still busy
	} state_t;

	state_t            state;
	logic              full;
	logic              take;
	regcore_pkg::cmd_t slot;

	// Latch only into an empty slot
	assign take = in_req && !full && (state != S_ACK);

	assign in_ack    = (state == S_ACK);
	assign cmd_valid = full;
	assign cmd       = slot;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= S_IDLE;
		else
		begin
			case (state)
				S_IDLE, S_WAIT_RELEASE:
				begin
					if (take)
						state <= S_ACK;
					else if (in_req)
						state <= S_WAIT_RELEASE;
				end
				S_ACK:
				begin
					if (!in_req)
						state <= S_IDLE; // Ack drops one cycle after req
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			full <= 1'b0;
		else if (take)
			full <= 1'b1;
		else if (cmd_valid && cmd_ready)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
			slot <= in_cmd;
	end

	a_ack_slot_free: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) |-> $past(!full));

endmodule

`default_nettype wire

/* hw/register_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module register_bank
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic [regcore_pkg::ADDR_W-1:0]  rd_addr_a,
	input  logic [regcore_pkg::ADDR_W-1:0]  rd_addr_b,
	output logic [regcore_pkg::DATA_W-1:0]  rd_data_a,
	output logic [regcore_pkg::DATA_W-1:0]  rd_data_b,
	input  logic                            wr_en,
	input  logic [regcore_pkg::ADDR_W-1:0]  wr_addr,
	input  logic [regcore_pkg::DATA_W-1:0]  wr_data
);

	logic [regcore_pkg::DATA_W-1:0] regs [regcore_pkg::REG_COUNT];

	////////////////////
	// Write port

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Each word starts out holding its own index
			for (int i = 0; i < regcore_pkg::REG_COUNT; i++)
				regs[i] <= regcore_pkg::word_t'(i);
		end
		else if (wr_en && (wr_addr != '0))
			regs[wr_addr] <= wr_data; // Writes to r0 are dropped
	end

	////////////////////
	// Read ports

	// Registered reads, old value on a same-edge write
	always_ff @(posedge clk)
	begin
		rd_data_a <= (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
		rd_data_b <= (rd_addr_b == '0) ? '0 : regs[rd_addr_b];
	end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu
(
	input  regcore_pkg::op_t               op,
	input  logic [regcore_pkg::DATA_W-1:0] a,
	input  logic [regcore_pkg::DATA_W-1:0] b,
	input  logic [regcore_pkg::IMM_W-1:0]  imm,
	output logic [regcore_pkg::DATA_W-1:0] y
);

	always_comb
	begin
		case (op)
			regcore_pkg::OP_ADD: y = a + b;
			regcore_pkg::OP_SUB: y = a - b;
			regcore_pkg::OP_AND: y = a & b;
			regcore_pkg::OP_OR:  y = a | b;
			regcore_pkg::OP_XOR: y = a ^ b;
			regcore_pkg::OP_SLT:
				y = regcore_pkg::word_t'($signed(a) < $signed(b));
			regcore_pkg::OP_LI:
				y = regcore_pkg::word_t'(imm); // Zero-extend
			default:
				y = '0; // Dump has no result here
		endcase
	end

endmodule

`default_nettype wire

/* hw/exec_control.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_control
(
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           cmd_valid,
	input  regcore_pkg::cmd_t              cmd,
	output logic                           cmd_ready,
	output logic                           res_valid,
	output regcore_pkg::result_t           res,
	input  logic                           res_ready,
	output logic [regcore_pkg::ADDR_W-1:0] rd_addr_a,
	output logic [regcore_pkg::ADDR_W-1:0] rd_addr_b,
	input  logic [regcore_pkg::DATA_W-1:0] rd_data_a,
	input  logic [regcore_pkg::DATA_W-1:0] rd_data_b,
	output logic                           wr_en,
	output logic [regcore_pkg::ADDR_W-1:0] wr_addr,
	output logic [regcore_pkg::DATA_W-1:0] wr_data,
	output regcore_pkg::op_t               alu_op,
	output logic [regcore_pkg::DATA_W-1:0] alu_a,
	output logic [regcore_pkg::DATA_W-1:0] alu_b,
	output logic [regcore_pkg::IMM_W-1:0]  alu_imm,
	input  logic [regcore_pkg::DATA_W-1:0] alu_y
);

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_READ,      // Operands valid
		S_EXEC,      // Write back and result
		S_DUMP_READ,
		S_DUMP_EMIT
	} state_t;

	state_t                         state;
	regcore_pkg::cmd_t              cmd_q;
	logic [regcore_pkg::ADDR_W-1:0] dump_cnt;
	logic [regcore_pkg::DATA_W-1:0] res_data;
	logic                           take;
	logic                           dumping;

	assign take    = cmd_valid && cmd_ready;
	assign dumping = (state == S_DUMP_READ) || (state == S_DUMP_EMIT);

	assign cmd_ready = (state == S_IDLE);
	assign res_valid = (state == S_EXEC) || (state == S_DUMP_EMIT);

	// While idle the read goes out with the incoming command
	assign rd_addr_a = (state == S_IDLE) ? cmd.rs : (dumping ? dump_cnt : cmd_q.rs);
	assign rd_addr_b = (state == S_IDLE) ? cmd.rt : cmd_q.rt;

	assign alu_op  = cmd_q.op;
	assign alu_a   = rd_data_a;
	assign alu_b   = rd_data_b;
	assign alu_imm = cmd_q.imm;

	assign wr_en   = (state == S_EXEC) && res_ready; // Only on the result transfer
	assign wr_addr = cmd_q.rd;
	assign wr_data = res_data;

	assign res.addr = dumping ? dump_cnt : cmd_q.rd;
	assign res.data = dumping ? rd_data_a : res_data;
	assign res.dump = dumping;

	////////////////////
	// Sequencer

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= S_IDLE;
			dump_cnt <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					dump_cnt <= '0;
					if (take)
						state <= (cmd.op == regcore_pkg::OP_DUMP) ? S_DUMP_READ : S_READ;
				end
				S_READ:
					state <= S_EXEC;
				S_EXEC:
				begin
					if (res_ready)
						state <= S_IDLE;
				end
				S_DUMP_READ:
					state <= S_DUMP_EMIT;
				S_DUMP_EMIT:
				begin
					if (res_ready && (dump_cnt == regcore_pkg::LAST_REG))
						state <= S_IDLE;
					else if (res_ready)
					begin
						dump_cnt <= dump_cnt + 1'b1; // Next register
						state    <= S_DUMP_READ;
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			cmd_q <= cmd;
		if (state == S_READ)
			res_data <= alu_y; // Held through any stall
	end

	a_no_write_in_dump: assert property (@(posedge clk) disable iff (reset)
		dumping |-> !wr_en);

endmodule

`default_nettype wire

/* hw/result_sender.sv */
`timescale 1ns/10ps
`default_nettype none

module result_sender
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 res_valid,
	input  regcore_pkg::result_t res,
	output logic                 res_ready,
	output logic                 out_req,
	output regcore_pkg::result_t out_res,
	input  logic                 out_ack
);

	typedef enum logic [1:0]
	{
		S_EMPTY,
		S_REQ,     // Req high, waiting for ack
		S_RELEASE  // Req low, waiting for ack to drop
	} state_t;

	state_t               state;
	regcore_pkg::result_t slot;

	assign res_ready = (state == S_EMPTY);
	assign out_req   = (state == S_REQ);
	assign out_res   = slot;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= S_EMPTY;
		else
		begin
			case (state)
				S_EMPTY:
				begin
					if (res_valid)
						state <= S_REQ;
				end
				S_REQ:
				begin
					if (out_ack)
						state <= S_RELEASE;
				end
				S_RELEASE:
				begin
					if (!out_ack)
						state <= S_EMPTY; // Slot free again
				end
				default:
					state <= S_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (res_valid && res_ready)
			slot <= res;
	end

	a_out_res_stable: assert property (@(posedge clk) disable iff (reset)
		out_req |=> (!out_req || $stable(out_res)));

endmodule

`default_nettype wire

/* hw/regcore_top.sv */
`timescale 1ns/10ps
`default_nettype none

module regcore_top
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_req,
	input  regcore_pkg::cmd_t    in_cmd,
	output logic                 in_ack,
	output logic                 out_req,
	output regcore_pkg::result_t out_res,
	input  logic                 out_ack
);

	////////////////////
	// Internal links

	logic                           cmd_valid;
	logic                           cmd_ready;
	regcore_pkg::cmd_t              cmd;
	logic                           res_valid;
	logic                           res_ready;
	regcore_pkg::result_t           res;

	logic [regcore_pkg::ADDR_W-1:0] rd_addr_a;
	logic [regcore_pkg::ADDR_W-1:0] rd_addr_b;
	logic [regcore_pkg::DATA_W-1:0] rd_data_a;
	logic [regcore_pkg::DATA_W-1:0] rd_data_b;
	logic                           wr_en;
	logic [regcore_pkg::ADDR_W-1:0] wr_addr;
	logic [regcore_pkg::DATA_W-1:0] wr_data;

	regcore_pkg::op_t               alu_op;
	logic [regcore_pkg::DATA_W-1:0] alu_a;
	logic [regcore_pkg::DATA_W-1:0] alu_b;
	logic [regcore_pkg::IMM_W-1:0]  alu_imm;
	logic [regcore_pkg::DATA_W-1:0] alu_y;

	cmd_receiver u_cmd_receiver
	(
		.clk       (clk),
		.reset     (reset),
		.in_req    (in_req),
		.in_cmd    (in_cmd),
		.in_ack    (in_ack),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready)
	);

	exec_control u_exec_control
	(
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.alu_op    (alu_op),
		.alu_a     (alu_a),
		.alu_b     (alu_b),
		.alu_imm   (alu_imm),
		.alu_y     (alu_y)
	);

	register_bank u_register_bank
	(
		.clk       (clk),
		.reset     (reset),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	alu u_alu
	(
		.op  (alu_op),
		.a   (alu_a),
		.b   (alu_b),
		.imm (alu_imm),
		.y   (alu_y)
	);

	result_sender u_result_sender
	(
		.clk       (clk),
		.reset     (reset),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready),
		.out_req   (out_req),
		.out_res   (out_res),
		.out_ack   (out_ack)
	);

endmodule

`default_nettype wire

/* sim/tb_regcore.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_regcore;

	localparam int TIMEOUT = 5000; // Cycles allowed per wait

	logic                 clk;
	logic                 reset;
	logic                 in_req;
	regcore_pkg::cmd_t    in_cmd;
	logic                 in_ack;
	logic                 out_req;
	regcore_pkg::result_t out_res;
	logic                 out_ack;

	logic [31:0]          model [32]; // Expected bank contents
	regcore_pkg::result_t expected [$];
	int                   errors;
	int                   proto_errors;
	int                   max_delay;   // Upper bound of out_ack delay
	bit                   aborted;
	bit                   stop;

	regcore_top dut
	(
		.clk     (clk),
		.reset   (reset),
		.in_req  (in_req),
		.in_cmd  (in_cmd),
		.in_ack  (in_ack),
		.out_req (out_req),
		.out_res (out_res),
		.out_ack (out_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// Protocol checks

	a_in_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) |-> $past(in_req))
	else
	begin
		proto_errors++;
		$display("Protocol error: in_ack rose while in_req was low");
	end

	a_in_ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(in_ack) |-> $past(!in_req))
	else
	begin
		proto_errors++;
		$display("Protocol error: in_ack fell before in_req was released");
	end

	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		(out_req && $past(out_req)) |-> $stable(out_res))
	else
	begin
		proto_errors++;
		$display("Protocol error: out_res changed while out_req was high");
	end

	a_out_req_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(out_req) |-> $past(!out_ack))
	else
	begin
		proto_errors++;
		$display("Protocol error: out_req rose before out_ack had fallen");
	end

	////////////////////
	// Reference model

	function automatic logic [31:0] predict(regcore_pkg::op_t op, logic [31:0] a,
		logic [31:0] b, logic [15:0] imm);
		case (op)
			regcore_pkg::OP_ADD: return a + b;
			regcore_pkg::OP_SUB: return a - b;
			regcore_pkg::OP_AND: return a & b;
			regcore_pkg::OP_OR:  return a | b;
			regcore_pkg::OP_XOR: return a ^ b;
			regcore_pkg::OP_SLT: return {31'd0, $signed(a) < $signed(b)};
			regcore_pkg::OP_LI:  return {16'd0, imm};
			default:             return 32'd0;
		endcase
	endfunction

	// Four-phase master on the input link
	task automatic send_cmd(input regcore_pkg::cmd_t c);
		int n;
		if (aborted)
			return;
		@(negedge clk);
		in_cmd = c;
		in_req = 1'b1;
		n = 0;
		while (!in_ack && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!in_ack)
		begin
			$display("Timeout: in_ack never rose for a command");
			aborted = 1'b1;
		end
		repeat ($urandom_range(3, 0)) @(negedge clk); // Hold req a while after ack
		in_req = 1'b0;
		n = 0;
		while (in_ack && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (in_ack)
		begin
			$display("Timeout: in_ack stayed high after in_req fell");
			aborted = 1'b1;
		end
	endtask

	task automatic send_random();
		regcore_pkg::cmd_t    c;
		regcore_pkg::result_t rec;
		c.op     = regcore_pkg::op_t'(3'($urandom_range(6, 0)));
		c.rs     = 5'($urandom);
		c.rt     = 5'($urandom);
		c.rd     = 5'($urandom);
		c.imm    = 16'($urandom);
		rec.addr = c.rd;
		rec.data = predict(c.op, model[c.rs], model[c.rt], c.imm);
		rec.dump = 1'b0;
		if (c.rd != 5'd0)
			model[c.rd] = rec.data; // r0 never stores
		expected.push_back(rec);
		send_cmd(c);
	endtask

	task automatic send_dump();
		regcore_pkg::cmd_t    c;
		regcore_pkg::result_t rec;
		c    = '0;
		c.op = regcore_pkg::OP_DUMP;
		for (int i = 0; i < 32; i++)
		begin
			rec.addr = 5'(i);
			rec.data = model[i];
			rec.dump = 1'b1;
			expected.push_back(rec);
		end
		send_cmd(c);
	endtask

	task automatic check_record();
		regcore_pkg::result_t exp;
		a_have_expected: assert (expected.size() != 0)
		else
		begin
			errors++;
			$display("Unexpected extra record from the DUT");
		end
		if (expected.size() != 0)
		begin
			exp = expected.pop_front();
			a_record: assert (out_res == exp)
			else
			begin
				errors++;
				$display("[ERROR] out_res addr/data/dump got %h/%h/%h expected %h/%h/%h",
					out_res.addr, out_res.data, out_res.dump, exp.addr, exp.data, exp.dump);
			end
		end
	endtask

	// Four-phase slave on the output link
	task automatic respond();
		int n;
		int delay;
		while (!stop && !aborted)
		begin
			n = 0;
			while (!out_req && !stop && n < TIMEOUT)
			begin
				@(negedge clk);
				n++;
			end
			if (!out_req && !stop)
			begin
				$display("Timeout: no out_req arrived from the DUT");
				aborted = 1'b1;
			end
			else if (out_req)
			begin
				check_record();
				delay = $urandom_range(max_delay, 0);
				repeat (delay) @(negedge clk);
				out_ack = 1'b1;
				n = 0;
				while (out_req && n < TIMEOUT)
				begin
					@(negedge clk);
					n++;
				end
				if (out_req)
				begin
					$display("Timeout: out_req stayed high after out_ack rose");
					aborted = 1'b1;
				end
				out_ack = 1'b0;
			end
		end
	endtask

	////////////////////
	// Main sequence

	initial
	begin
		int unsigned seed;
		int          n;
		seed         = $urandom(32'hf55b_a64b);
		errors       = 0;
		proto_errors = 0;
		aborted      = 1'b0;
		stop         = 1'b0;
		max_delay    = 5;
		reset        = 1'b1;
		in_req       = 1'b0;
		in_cmd       = '0;
		out_ack      = 1'b0;
		for (int i = 0; i < 32; i++)
			model[i] = i; // Reset pattern
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		a_reset_idle: assert (!in_ack && !out_req)
		else
		begin
			errors++;
			$display("[ERROR] in_ack/out_req after reset got %h/%h expected 0/0",
				in_ack, out_req);
		end
		fork
			respond();
		join_none
		send_dump();
		repeat (200) send_random();
		max_delay = 40; // Slow consumer
		repeat (16) send_random();
		max_delay = 5;
		send_dump();
		n = 0;
		while ((expected.size() != 0 || out_req || out_ack) && !aborted && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (expected.size() != 0)
		begin
			$display("Timeout: %0d records never arrived", expected.size());
			aborted = 1'b1;
		end
		stop = 1'b1;
		@(negedge clk);
		$display("Errors: %0d record, %0d protocol, aborted %0d", errors, proto_errors, aborted);
		if (errors == 0 && proto_errors == 0 && !aborted)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hw/regcore_pkg.sv
hw/cmd_receiver.sv
hw/register_bank.sv
hw/alu.sv
hw/exec_control.sv
hw/result_sender.sv
hw/regcore_top.sv
sim/tb_regcore.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_regcore -o sim_regcore
	./obj_dir/sim_regcore | tee sim.log
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
